//--- Makefile
VERILATOR ?= verilator
TOP ?= mem_subsystem_tb
RTL_TOP ?= mem_subsystem
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_TEXT ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/axi_lite_arbiter.sv
module axi_lite_arbiter (
	input  logic                clk,
	input  logic                rst,

	input  axi_lite_pkg::addr_t fetch_araddr,
	input  logic                fetch_arvalid,
	output logic                fetch_arready,
	output axi_lite_pkg::data_t fetch_rdata,
	output axi_lite_pkg::resp_t fetch_rresp,
	output logic                fetch_rvalid,
	input  logic                fetch_rready,

	input  axi_lite_pkg::addr_t ls_araddr,
	input  logic                ls_arvalid,
	output logic                ls_arready,
	output axi_lite_pkg::data_t ls_rdata,
	output axi_lite_pkg::resp_t ls_rresp,
	output logic                ls_rvalid,
	input  logic                ls_rready,
	input  axi_lite_pkg::addr_t ls_awaddr,
	input  logic                ls_awvalid,
	output logic                ls_awready,
	input  axi_lite_pkg::data_t ls_wdata,
	input  axi_lite_pkg::strb_t ls_wstrb,
	input  logic                ls_wvalid,
	output logic                ls_wready,
	output axi_lite_pkg::resp_t ls_bresp,
	output logic                ls_bvalid,
	input  logic                ls_bready,

	output axi_lite_pkg::addr_t araddr,
	output logic                arvalid,
	input  logic                arready,
	input  axi_lite_pkg::data_t rdata,
	input  axi_lite_pkg::resp_t rresp,
	input  logic                rvalid,
	output logic                rready,
	output axi_lite_pkg::addr_t awaddr,
	output logic                awvalid,
	input  logic                awready,
	output axi_lite_pkg::data_t wdata,
	output axi_lite_pkg::strb_t wstrb,
	output logic                wvalid,
	input  logic                wready,
	input  axi_lite_pkg::resp_t bresp,
	input  logic                bvalid,
	output logic                bready
);
	core_mem_pkg::grant_t grant;
	logic fetch_trigger;
	logic ls_trigger;
	logic resp_done;
	logic gnt_fetch;
	logic gnt_ls;

	// the fetch side only reads, so its write channels count as idle
	assign fetch_trigger = fetch_arvalid;
	assign ls_trigger    = ls_arvalid || (ls_awvalid && ls_wvalid);

	// release only once the response beat has actually transferred
	assign resp_done = (rvalid && rready) || (bvalid && bready);

	assign gnt_fetch = (grant == core_mem_pkg::GRANT_FETCH);
	assign gnt_ls    = (grant == core_mem_pkg::GRANT_LS);

	always_ff @(posedge clk) begin
		if (!rst) begin
			grant <= core_mem_pkg::GRANT_NONE;
		end else begin
			case (grant)
				core_mem_pkg::GRANT_NONE: begin
					if (fetch_trigger) begin
						grant <= core_mem_pkg::GRANT_FETCH;
					end else if (ls_trigger) begin
						grant <= core_mem_pkg::GRANT_LS;
					end
				end
				default: begin
					if (resp_done) begin
						grant <= core_mem_pkg::GRANT_NONE;
					end
				end
			endcase
		end
	end

	always_comb begin
		araddr  = gnt_fetch ? fetch_araddr : ls_araddr;
		arvalid = (gnt_fetch && fetch_arvalid) || (gnt_ls && ls_arvalid);
		rready  = (gnt_fetch && fetch_rready) || (gnt_ls && ls_rready);
		awaddr  = ls_awaddr;
		awvalid = gnt_ls && ls_awvalid;
		wdata   = ls_wdata;
		wstrb   = ls_wstrb;
		wvalid  = gnt_ls && ls_wvalid;
		bready  = gnt_ls && ls_bready;

		// the master without the grant sees no ready and no response
		fetch_arready = gnt_fetch && arready;
		fetch_rvalid  = gnt_fetch && rvalid;
		fetch_rdata   = rdata;
		fetch_rresp   = rresp;
		ls_arready    = gnt_ls && arready;
		ls_rvalid     = gnt_ls && rvalid;
		ls_rdata      = rdata;
		ls_rresp      = rresp;
		ls_awready    = gnt_ls && awready;
		ls_wready     = gnt_ls && wready;
		ls_bvalid     = gnt_ls && bvalid;
		ls_bresp      = bresp;
	end
endmodule

//--- hdl/axi_lite_pkg.sv
`include "bus_settings.svh"

package axi_lite_pkg;

	// one write strobe bit per byte lane of the data word
	localparam int STRB_W = `DATA_W / 8;

	// byte address, the low two bits are ignored by the SRAM
	typedef logic [`ADDR_W-1:0] addr_t;

	typedef logic [`DATA_W-1:0] data_t;

	typedef logic [STRB_W-1:0] strb_t;

	typedef logic [1:0] resp_t;

	// only these two codes come back from the SRAM
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

endpackage

//--- hdl/axi_lite_sram.sv
`include "bus_settings.svh"

module axi_lite_sram (
	input  logic                clk,
	input  logic                rst,

	input  axi_lite_pkg::addr_t araddr,
	input  logic                arvalid,
	output logic                arready,
	output axi_lite_pkg::data_t rdata,
	output axi_lite_pkg::resp_t rresp,
	output logic                rvalid,
	input  logic                rready,
	input  axi_lite_pkg::addr_t awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  axi_lite_pkg::data_t wdata,
	input  axi_lite_pkg::strb_t wstrb,
	input  logic                wvalid,
	output logic                wready,
	output axi_lite_pkg::resp_t bresp,
	output logic                bvalid,
	input  logic                bready
);
	localparam int WORDS = 1 << `MEM_WORDS_LOG2;

	axi_lite_pkg::data_t mem [WORDS];
	logic idle;
	logic rd_accept;
	logic wr_accept;
	logic rd_in_range;
	logic wr_in_range;
	logic [`MEM_WORDS_LOG2-1:0] rd_idx;
	logic [`MEM_WORDS_LOG2-1:0] wr_idx;

	// one access at a time, a pending response blocks new requests
	assign idle    = !rvalid && !bvalid;
	assign arready = idle;

	// a write needs AW and W in the same cycle, reads go first
	assign wr_accept = idle && !arvalid && awvalid && wvalid;
	assign awready   = wr_accept;
	assign wready    = wr_accept;
	assign rd_accept = arvalid && arready;

	assign rd_idx      = araddr[`MEM_WORDS_LOG2+1:2];
	assign wr_idx      = awaddr[`MEM_WORDS_LOG2+1:2];
	assign rd_in_range = (araddr[`ADDR_W-1:`MEM_WORDS_LOG2+2] == '0);
	assign wr_in_range = (awaddr[`ADDR_W-1:`MEM_WORDS_LOG2+2] == '0);

	always_ff @(posedge clk) begin
		if (!rst) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (rd_accept) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			if (wr_accept) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept) begin
			rdata <= rd_in_range ? mem[rd_idx] : '0;
			rresp <= rd_in_range ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
		end
		if (wr_accept) begin
			bresp <= wr_in_range ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
			// only the lanes with their strobe set change
			for (int i = 0; i < axi_lite_pkg::STRB_W; i++) begin
				if (wr_in_range && wstrb[i]) begin
					mem[wr_idx][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end
endmodule

//--- hdl/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// width of a byte address on the shared bus
`define ADDR_W 32

// width of one data word on the shared bus
`define DATA_W 32

// the SRAM holds 2**MEM_WORDS_LOG2 words
// word addresses past the end answer with SLVERR
`define MEM_WORDS_LOG2 10

`endif

//--- hdl/core_mem_pkg.sv
package core_mem_pkg;

	// owner of the shared bus, this is the arbiter's state
	typedef enum logic [1:0] {
		GRANT_NONE,
		GRANT_FETCH,
		GRANT_LS
	} grant_t;

	// common request sequence of both masters
	// M_ADDR presents the address (and write data), M_RESP waits for R or B
	typedef enum logic [1:0] {
		M_IDLE,
		M_ADDR,
		M_RESP
	} master_state_t;

endpackage

//--- hdl/fetch_master.sv
module fetch_master (
	input  logic                clk,
	input  logic                rst,

	input  logic                fetch_req,
	input  axi_lite_pkg::addr_t fetch_pc,
	output logic                fetch_done,
	output axi_lite_pkg::data_t fetch_inst,
	output logic                fetch_err,

	output axi_lite_pkg::addr_t araddr,
	output logic                arvalid,
	input  logic                arready,
	input  axi_lite_pkg::data_t rdata,
	input  axi_lite_pkg::resp_t rresp,
	input  logic                rvalid,
	output logic                rready
);
	core_mem_pkg::master_state_t state;

	assign arvalid = (state == core_mem_pkg::M_ADDR);
	assign rready  = (state == core_mem_pkg::M_RESP);

	always_ff @(posedge clk) begin
		if (!rst) begin
			state      <= core_mem_pkg::M_IDLE;
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			case (state)
				core_mem_pkg::M_IDLE: begin
					// a strobe outside M_IDLE is dropped
					if (fetch_req) begin
						state <= core_mem_pkg::M_ADDR;
					end
				end
				core_mem_pkg::M_ADDR: begin
					if (arready) begin
						state <= core_mem_pkg::M_RESP;
					end
				end
				core_mem_pkg::M_RESP: begin
					if (rvalid) begin
						fetch_done <= 1'b1;
						state      <= core_mem_pkg::M_IDLE;
					end
				end
				default: begin
					state <= core_mem_pkg::M_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == core_mem_pkg::M_IDLE && fetch_req) begin
			araddr <= fetch_pc;
		end
		if (state == core_mem_pkg::M_RESP && rvalid) begin
			fetch_inst <= rdata;
			fetch_err  <= (rresp != axi_lite_pkg::RESP_OKAY);
		end
	end
endmodule

//--- hdl/load_store_master.sv
module load_store_master (
	input  logic                clk,
	input  logic                rst,

	input  logic                ls_req,
	input  logic                ls_write,
	input  axi_lite_pkg::addr_t ls_addr,
	input  axi_lite_pkg::data_t ls_wdata,
	input  axi_lite_pkg::strb_t ls_wstrb,
	output logic                ls_done,
	output axi_lite_pkg::data_t ls_rdata,
	output logic                ls_err,

	output axi_lite_pkg::addr_t araddr,
	output logic                arvalid,
	input  logic                arready,
	input  axi_lite_pkg::data_t rdata,
	input  axi_lite_pkg::resp_t rresp,
	input  logic                rvalid,
	output logic                rready,
	output axi_lite_pkg::addr_t awaddr,
	output logic                awvalid,
	input  logic                awready,
	output axi_lite_pkg::data_t wdata,
	output axi_lite_pkg::strb_t wstrb,
	output logic                wvalid,
	input  logic                wready,
	input  axi_lite_pkg::resp_t bresp,
	input  logic                bvalid,
	output logic                bready
);
	core_mem_pkg::master_state_t state;
	axi_lite_pkg::addr_t addr_q;
	logic is_write;
	logic aw_done;
	logic w_done;
	logic aw_ok;
	logic w_ok;
	logic in_addr;
	logic in_resp;

	assign in_addr = (state == core_mem_pkg::M_ADDR);
	assign in_resp = (state == core_mem_pkg::M_RESP);

	// the same latched address serves both address channels
	assign araddr  = addr_q;
	assign awaddr  = addr_q;
	assign arvalid = in_addr && !is_write;
	assign awvalid = in_addr && is_write && !aw_done;
	assign wvalid  = in_addr && is_write && !w_done;
	assign rready  = in_resp && !is_write;
	assign bready  = in_resp && is_write;

	// AW and W may be accepted in different cycles
	assign aw_ok = aw_done || (awvalid && awready);
	assign w_ok  = w_done || (wvalid && wready);

	always_ff @(posedge clk) begin
		if (!rst) begin
			state    <= core_mem_pkg::M_IDLE;
			is_write <= 1'b0;
			aw_done  <= 1'b0;
			w_done   <= 1'b0;
			ls_done  <= 1'b0;
		end else begin
			ls_done <= 1'b0;
			case (state)
				core_mem_pkg::M_IDLE: begin
					if (ls_req) begin
						is_write <= ls_write;
						aw_done  <= 1'b0;
						w_done   <= 1'b0;
						state    <= core_mem_pkg::M_ADDR;
					end
				end
				core_mem_pkg::M_ADDR: begin
					if (!is_write && arready) begin
						state <= core_mem_pkg::M_RESP;
					end else if (is_write && aw_ok && w_ok) begin
						state <= core_mem_pkg::M_RESP;
					end else begin
						aw_done <= aw_ok;
						w_done  <= w_ok;
					end
				end
				core_mem_pkg::M_RESP: begin
					if ((rready && rvalid) || (bready && bvalid)) begin
						ls_done <= 1'b1;
						state   <= core_mem_pkg::M_IDLE;
					end
				end
				default: begin
					state <= core_mem_pkg::M_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == core_mem_pkg::M_IDLE && ls_req) begin
			addr_q <= ls_addr;
			wdata  <= ls_wdata;
			wstrb  <= ls_wstrb;
		end
		if (rready && rvalid) begin
			ls_rdata <= rdata;
			ls_err   <= (rresp != axi_lite_pkg::RESP_OKAY);
		end
		// a store reports only its status, ls_rdata keeps the last load
		if (bready && bvalid) begin
			ls_err <= (bresp != axi_lite_pkg::RESP_OKAY);
		end
	end
endmodule

//--- hdl/mem_subsystem.sv
module mem_subsystem (
	input  logic                clk,
	input  logic                rst,

	input  logic                fetch_req,
	input  axi_lite_pkg::addr_t fetch_pc,
	output logic                fetch_done,
	output axi_lite_pkg::data_t fetch_inst,
	output logic                fetch_err,

	input  logic                ls_req,
	input  logic                ls_write,
	input  axi_lite_pkg::addr_t ls_addr,
	input  axi_lite_pkg::data_t ls_wdata,
	input  axi_lite_pkg::strb_t ls_wstrb,
	output logic                ls_done,
	output axi_lite_pkg::data_t ls_rdata,
	output logic                ls_err
);
	axi_lite_pkg::addr_t fetch_axi_araddr;
	logic                fetch_axi_arvalid;
	logic                fetch_axi_arready;
	axi_lite_pkg::data_t fetch_axi_rdata;
	axi_lite_pkg::resp_t fetch_axi_rresp;
	logic                fetch_axi_rvalid;
	logic                fetch_axi_rready;

	axi_lite_pkg::addr_t ls_axi_araddr;
	logic                ls_axi_arvalid;
	logic                ls_axi_arready;
	axi_lite_pkg::data_t ls_axi_rdata;
	axi_lite_pkg::resp_t ls_axi_rresp;
	logic                ls_axi_rvalid;
	logic                ls_axi_rready;
	axi_lite_pkg::addr_t ls_axi_awaddr;
	logic                ls_axi_awvalid;
	logic                ls_axi_awready;
	axi_lite_pkg::data_t ls_axi_wdata;
	axi_lite_pkg::strb_t ls_axi_wstrb;
	logic                ls_axi_wvalid;
	logic                ls_axi_wready;
	axi_lite_pkg::resp_t ls_axi_bresp;
	logic                ls_axi_bvalid;
	logic                ls_axi_bready;

	axi_lite_pkg::addr_t mem_araddr;
	logic                mem_arvalid;
	logic                mem_arready;
	axi_lite_pkg::data_t mem_rdata;
	axi_lite_pkg::resp_t mem_rresp;
	logic                mem_rvalid;
	logic                mem_rready;
	axi_lite_pkg::addr_t mem_awaddr;
	logic                mem_awvalid;
	logic                mem_awready;
	axi_lite_pkg::data_t mem_wdata;
	axi_lite_pkg::strb_t mem_wstrb;
	logic                mem_wvalid;
	logic                mem_wready;
	axi_lite_pkg::resp_t mem_bresp;
	logic                mem_bvalid;
	logic                mem_bready;

	fetch_master fetch_master_i (
		.clk        (clk),
		.rst        (rst),
		.fetch_req  (fetch_req),
		.fetch_pc   (fetch_pc),
		.fetch_done (fetch_done),
		.fetch_inst (fetch_inst),
		.fetch_err  (fetch_err),
		.araddr     (fetch_axi_araddr),
		.arvalid    (fetch_axi_arvalid),
		.arready    (fetch_axi_arready),
		.rdata      (fetch_axi_rdata),
		.rresp      (fetch_axi_rresp),
		.rvalid     (fetch_axi_rvalid),
		.rready     (fetch_axi_rready)
	);

	load_store_master load_store_master_i (
		.clk      (clk),
		.rst      (rst),
		.ls_req   (ls_req),
		.ls_write (ls_write),
		.ls_addr  (ls_addr),
		.ls_wdata (ls_wdata),
		.ls_wstrb (ls_wstrb),
		.ls_done  (ls_done),
		.ls_rdata (ls_rdata),
		.ls_err   (ls_err),
		.araddr   (ls_axi_araddr),
		.arvalid  (ls_axi_arvalid),
		.arready  (ls_axi_arready),
		.rdata    (ls_axi_rdata),
		.rresp    (ls_axi_rresp),
		.rvalid   (ls_axi_rvalid),
		.rready   (ls_axi_rready),
		.awaddr   (ls_axi_awaddr),
		.awvalid  (ls_axi_awvalid),
		.awready  (ls_axi_awready),
		.wdata    (ls_axi_wdata),
		.wstrb    (ls_axi_wstrb),
		.wvalid   (ls_axi_wvalid),
		.wready   (ls_axi_wready),
		.bresp    (ls_axi_bresp),
		.bvalid   (ls_axi_bvalid),
		.bready   (ls_axi_bready)
	);

	axi_lite_arbiter axi_lite_arbiter_i (
		.clk           (clk),
		.rst           (rst),
		.fetch_araddr  (fetch_axi_araddr),
		.fetch_arvalid (fetch_axi_arvalid),
		.fetch_arready (fetch_axi_arready),
		.fetch_rdata   (fetch_axi_rdata),
		.fetch_rresp   (fetch_axi_rresp),
		.fetch_rvalid  (fetch_axi_rvalid),
		.fetch_rready  (fetch_axi_rready),
		.ls_araddr     (ls_axi_araddr),
		.ls_arvalid    (ls_axi_arvalid),
		.ls_arready    (ls_axi_arready),
		.ls_rdata      (ls_axi_rdata),
		.ls_rresp      (ls_axi_rresp),
		.ls_rvalid     (ls_axi_rvalid),
		.ls_rready     (ls_axi_rready),
		.ls_awaddr     (ls_axi_awaddr),
		.ls_awvalid    (ls_axi_awvalid),
		.ls_awready    (ls_axi_awready),
		.ls_wdata      (ls_axi_wdata),
		.ls_wstrb      (ls_axi_wstrb),
		.ls_wvalid     (ls_axi_wvalid),
		.ls_wready     (ls_axi_wready),
		.ls_bresp      (ls_axi_bresp),
		.ls_bvalid     (ls_axi_bvalid),
		.ls_bready     (ls_axi_bready),
		.araddr        (mem_araddr),
		.arvalid       (mem_arvalid),
		.arready       (mem_arready),
		.rdata         (mem_rdata),
		.rresp         (mem_rresp),
		.rvalid        (mem_rvalid),
		.rready        (mem_rready),
		.awaddr        (mem_awaddr),
		.awvalid       (mem_awvalid),
		.awready       (mem_awready),
		.wdata         (mem_wdata),
		.wstrb         (mem_wstrb),
		.wvalid        (mem_wvalid),
		.wready        (mem_wready),
		.bresp         (mem_bresp),
		.bvalid        (mem_bvalid),
		.bready        (mem_bready)
	);

	axi_lite_sram axi_lite_sram_i (
		.clk     (clk),
		.rst     (rst),
		.araddr  (mem_araddr),
		.arvalid (mem_arvalid),
		.arready (mem_arready),
		.rdata   (mem_rdata),
		.rresp   (mem_rresp),
		.rvalid  (mem_rvalid),
		.rready  (mem_rready),
		.awaddr  (mem_awaddr),
		.awvalid (mem_awvalid),
		.awready (mem_awready),
		.wdata   (mem_wdata),
		.wstrb   (mem_wstrb),
		.wvalid  (mem_wvalid),
		.wready  (mem_wready),
		.bresp   (mem_bresp),
		.bvalid  (mem_bvalid),
		.bready  (mem_bready)
	);
endmodule

//--- project.f
+incdir+hdl
hdl/axi_lite_pkg.sv
hdl/core_mem_pkg.sv
hdl/fetch_master.sv
hdl/load_store_master.sv
hdl/axi_lite_arbiter.sv
hdl/axi_lite_sram.sv
hdl/mem_subsystem.sv
sim/clock_gen.sv
sim/mem_subsystem_props.sv
sim/mem_subsystem_tb.sv

//--- sim/clock_gen.sv
module clock_gen (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset stays low for four rising edges, then lets go just after the fourth
	initial begin
		rst = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst = 1'b1;
	end
endmodule

//--- sim/mem_subsystem_props.sv
module mem_subsystem_props (
	input logic                 clk,
	input logic                 rst,
	input core_mem_pkg::grant_t grant,
	input logic                 fetch_arvalid,
	input logic                 fetch_arready,
	input logic                 fetch_rvalid,
	input logic                 fetch_rready,
	input logic                 ls_arvalid,
	input logic                 ls_arready,
	input logic                 ls_rvalid,
	input logic                 ls_rready,
	input logic                 ls_awvalid,
	input logic                 ls_awready,
	input logic                 ls_wvalid,
	input logic                 ls_wready,
	input logic                 ls_bvalid,
	input logic                 ls_bready,
	input axi_lite_pkg::addr_t  araddr,
	input logic                 arvalid,
	input logic                 arready,
	input logic                 rvalid,
	input axi_lite_pkg::addr_t  awaddr,
	input logic                 awvalid,
	input logic                 awready,
	input axi_lite_pkg::data_t  wdata,
	input axi_lite_pkg::strb_t  wstrb,
	input logic                 wvalid,
	input logic                 wready,
	input logic                 bvalid
);
	timeunit 1ns;
	timeprecision 100ps;

	logic ls_trigger;
	int   fail_count = 0;

	assign ls_trigger = ls_arvalid || (ls_awvalid && ls_wvalid);

	one_side_ready: assert property (@(posedge clk) disable iff (!rst)
		!(fetch_arready && (ls_arready || ls_awready || ls_wready)))
		else begin
			$error("fetch and load/store readies are high in the same cycle");
			fail_count++;
		end

	ar_held: assert property (@(posedge clk) disable iff (!rst)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			$error("arvalid dropped or araddr changed before the AR transfer");
			fail_count++;
		end

	aw_held: assert property (@(posedge clk) disable iff (!rst)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			$error("awvalid dropped or awaddr changed before the AW transfer");
			fail_count++;
		end

	w_held: assert property (@(posedge clk) disable iff (!rst)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else begin
			$error("wvalid dropped or write data changed before the W transfer");
			fail_count++;
		end

	// first cycle out of reset
	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst) |-> !(arvalid || awvalid || wvalid || rvalid || bvalid
			|| fetch_arvalid || ls_arvalid || ls_awvalid || ls_wvalid))
		else begin
			$error("a valid is high in the first cycle after reset");
			fail_count++;
		end

	// the masters add one cycle on each side, so done follows the strobe by 4
	fetch_latency: assert property (@(posedge clk) disable iff (!rst)
		$rose(fetch_arvalid) && grant == core_mem_pkg::GRANT_NONE
		|-> ##2 (fetch_rvalid && fetch_rready))
		else begin
			$error("uncontended fetch read did not finish in the expected cycle");
			fail_count++;
		end

	ls_latency: assert property (@(posedge clk) disable iff (!rst)
		$rose(ls_trigger) && grant == core_mem_pkg::GRANT_NONE && !fetch_arvalid
		|-> ##2 ((ls_rvalid && ls_rready) || (ls_bvalid && ls_bready)))
		else begin
			$error("uncontended load/store did not finish in the expected cycle");
			fail_count++;
		end
endmodule

//--- sim/mem_subsystem_tb.sv
`include "bus_settings.svh"

module mem_subsystem_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 40;
	localparam logic [31:0] LFSR_SEED = 32'hb665c4d3;
	localparam int DRIVE_DELAY_NS = 1;
	localparam int DONE_LATENCY = 4;
	localparam int WORDS = 1 << `MEM_WORDS_LOG2;

	logic                clk;
	logic                rst;
	logic                fetch_req;
	axi_lite_pkg::addr_t fetch_pc;
	logic                fetch_done;
	axi_lite_pkg::data_t fetch_inst;
	logic                fetch_err;
	logic                ls_req;
	logic                ls_write;
	axi_lite_pkg::addr_t ls_addr;
	axi_lite_pkg::data_t ls_wdata;
	axi_lite_pkg::strb_t ls_wstrb;
	logic                ls_done;
	axi_lite_pkg::data_t ls_rdata;
	logic                ls_err;

	axi_lite_pkg::data_t shadow [WORDS];
	logic [31:0]         lfsr;
	string               test_name;
	axi_lite_pkg::data_t exp_fetch_inst;
	logic                exp_fetch_err;
	axi_lite_pkg::data_t exp_ls_rdata;
	logic                exp_ls_err;
	logic                exp_ls_load;
	int                  value_errors;
	int                  order_errors;
	int                  latency_errors;
	int                  protocol_errors;
	int                  timeouts;
	int                  fetch_count;
	int                  ls_count;

	clock_gen clock_gen_i (
		.clk (clk),
		.rst (rst)
	);

	mem_subsystem mem_subsystem_i (
		.clk        (clk),
		.rst        (rst),
		.fetch_req  (fetch_req),
		.fetch_pc   (fetch_pc),
		.fetch_done (fetch_done),
		.fetch_inst (fetch_inst),
		.fetch_err  (fetch_err),
		.ls_req     (ls_req),
		.ls_write   (ls_write),
		.ls_addr    (ls_addr),
		.ls_wdata   (ls_wdata),
		.ls_wstrb   (ls_wstrb),
		.ls_done    (ls_done),
		.ls_rdata   (ls_rdata),
		.ls_err     (ls_err)
	);

	bind axi_lite_arbiter mem_subsystem_props mem_subsystem_props_i (
		.clk           (clk),
		.rst           (rst),
		.grant         (grant),
		.fetch_arvalid (fetch_arvalid),
		.fetch_arready (fetch_arready),
		.fetch_rvalid  (fetch_rvalid),
		.fetch_rready  (fetch_rready),
		.ls_arvalid    (ls_arvalid),
		.ls_arready    (ls_arready),
		.ls_rvalid     (ls_rvalid),
		.ls_rready     (ls_rready),
		.ls_awvalid    (ls_awvalid),
		.ls_awready    (ls_awready),
		.ls_wvalid     (ls_wvalid),
		.ls_wready     (ls_wready),
		.ls_bvalid     (ls_bvalid),
		.ls_bready     (ls_bready),
		.araddr        (araddr),
		.arvalid       (arvalid),
		.arready       (arready),
		.rvalid        (rvalid),
		.awaddr        (awaddr),
		.awvalid       (awvalid),
		.awready       (awready),
		.wdata         (wdata),
		.wstrb         (wstrb),
		.wvalid        (wvalid),
		.wready        (wready),
		.bvalid        (bvalid)
	);

	fetch_result: assert property (@(posedge clk) disable iff (!rst)
		fetch_done |-> (fetch_inst == exp_fetch_inst && fetch_err == exp_fetch_err))
		else begin
			$display("[ERROR] %s fetch: expected inst %h err %b, actual inst %h err %b",
				test_name, exp_fetch_inst, exp_fetch_err, fetch_inst, fetch_err);
			value_errors++;
		end

	// a store only reports its status, so rdata is compared for loads alone
	ls_result: assert property (@(posedge clk) disable iff (!rst)
		ls_done |-> (ls_err == exp_ls_err && (!exp_ls_load || ls_rdata == exp_ls_rdata)))
		else begin
			$display("[ERROR] %s load/store: expected rdata %h err %b, actual rdata %h err %b",
				test_name, exp_ls_rdata, exp_ls_err, ls_rdata, ls_err);
			value_errors++;
		end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr[31]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic axi_lite_pkg::addr_t word_addr(input int word, input int low_bits);
		return axi_lite_pkg::addr_t'(word * 4 + low_bits);
	endfunction

	function automatic logic in_range(input axi_lite_pkg::addr_t addr);
		return (addr >> 2) < 32'(WORDS);
	endfunction

	// out-of-range reads come back as zero
	function automatic axi_lite_pkg::data_t expected_read(input axi_lite_pkg::addr_t addr);
		if (!in_range(addr)) begin
			return '0;
		end
		return shadow[addr[`MEM_WORDS_LOG2+1:2]];
	endfunction

	function automatic axi_lite_pkg::data_t merge_bytes(input axi_lite_pkg::data_t old_word,
			input axi_lite_pkg::data_t new_word, input axi_lite_pkg::strb_t strb);
		axi_lite_pkg::data_t result;
		result = old_word;
		for (int b = 0; b < axi_lite_pkg::STRB_W; b++) begin
			if (strb[b]) begin
				result[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return result;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#(DRIVE_DELAY_NS);
	endtask

	// an uncontended in-range request finishes a fixed number of cycles after its strobe
	task automatic check_latency(input string side, input int waited, input logic enabled);
		if (enabled) begin
			latency_check: assert (waited + 1 == DONE_LATENCY)
				else begin
					$display("[ERROR] %s %s latency: expected %0d cycles, actual %0d",
						test_name, side, DONE_LATENCY, waited + 1);
					latency_errors++;
				end
		end
	endtask

	// the extra cycle at the end lets the result assertion sample the strobe
	task automatic wait_ls_done();
		int n;
		n = 0;
		while (!ls_done && n < TIMEOUT_CYCLES) begin
			next_cycle();
			n++;
		end
		if (ls_done) begin
			ls_count++;
			check_latency("load/store", n, !exp_ls_err);
		end else begin
			$display("%s: timed out waiting for the load/store done strobe", test_name);
			timeouts++;
		end
		next_cycle();
	endtask

	task automatic wait_fetch_done();
		int n;
		n = 0;
		while (!fetch_done && n < TIMEOUT_CYCLES) begin
			next_cycle();
			n++;
		end
		if (fetch_done) begin
			fetch_count++;
			check_latency("fetch", n, !exp_fetch_err);
		end else begin
			$display("%s: timed out waiting for the fetch done strobe", test_name);
			timeouts++;
		end
		next_cycle();
	endtask

	task automatic do_store(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
			input axi_lite_pkg::strb_t strb);
		exp_ls_load = 1'b0;
		exp_ls_err  = !in_range(addr);
		if (in_range(addr)) begin
			shadow[addr[`MEM_WORDS_LOG2+1:2]] = merge_bytes(expected_read(addr), data, strb);
		end
		ls_write = 1'b1;
		ls_addr  = addr;
		ls_wdata = data;
		ls_wstrb = strb;
		ls_req   = 1'b1;
		next_cycle();
		ls_req = 1'b0;
		wait_ls_done();
	endtask

	task automatic do_load(input axi_lite_pkg::addr_t addr);
		exp_ls_load  = 1'b1;
		exp_ls_err   = !in_range(addr);
		exp_ls_rdata = expected_read(addr);
		ls_write = 1'b0;
		ls_addr  = addr;
		ls_req   = 1'b1;
		next_cycle();
		ls_req = 1'b0;
		wait_ls_done();
	endtask

	task automatic do_fetch(input axi_lite_pkg::addr_t addr);
		exp_fetch_err  = !in_range(addr);
		exp_fetch_inst = expected_read(addr);
		fetch_pc  = addr;
		fetch_req = 1'b1;
		next_cycle();
		fetch_req = 1'b0;
		wait_fetch_done();
	endtask

	// both strobes arrive in one cycle and fetch has priority on the bus
	task automatic do_fetch_and_load(input axi_lite_pkg::addr_t pc,
			input axi_lite_pkg::addr_t addr);
		int n;
		int fetch_at;
		int ls_at;
		exp_fetch_err  = !in_range(pc);
		exp_fetch_inst = expected_read(pc);
		exp_ls_load    = 1'b1;
		exp_ls_err     = !in_range(addr);
		exp_ls_rdata   = expected_read(addr);
		fetch_pc  = pc;
		ls_write  = 1'b0;
		ls_addr   = addr;
		fetch_req = 1'b1;
		ls_req    = 1'b1;
		next_cycle();
		fetch_req = 1'b0;
		ls_req    = 1'b0;
		n = 0;
		fetch_at = -1;
		ls_at = -1;
		while ((fetch_at < 0 || ls_at < 0) && n < TIMEOUT_CYCLES) begin
			next_cycle();
			n++;
			if (fetch_done && fetch_at < 0) begin
				fetch_at = n;
				fetch_count++;
			end
			if (ls_done && ls_at < 0) begin
				ls_at = n;
				ls_count++;
			end
		end
		if (fetch_at < 0 || ls_at < 0) begin
			$display("%s: timed out waiting for both done strobes", test_name);
			timeouts++;
		end else begin
			order_check: assert (fetch_at < ls_at)
				else begin
					$display("[ERROR] %s order: expected fetch_done first, actual %0s",
						test_name, (fetch_at == ls_at) ? "same cycle" : "ls_done first");
					order_errors++;
				end
		end
		next_cycle();
	endtask

	initial begin
		int n;
		int word_a;
		int word_b;
		logic [31:0] bits;
		logic [31:0] data;

		fetch_req = 1'b0;
		fetch_pc  = '0;
		ls_req    = 1'b0;
		ls_write  = 1'b0;
		ls_addr   = '0;
		ls_wdata  = '0;
		ls_wstrb  = '0;
		exp_fetch_inst = '0;
		exp_fetch_err  = 1'b0;
		exp_ls_rdata   = '0;
		exp_ls_err     = 1'b0;
		exp_ls_load    = 1'b0;
		value_errors    = 0;
		order_errors    = 0;
		latency_errors  = 0;
		protocol_errors = 0;
		timeouts        = 0;
		fetch_count     = 0;
		ls_count        = 0;
		lfsr = LFSR_SEED;
		test_name = "reset";

		n = 0;
		@(posedge clk);
		while (!rst && n < TIMEOUT_CYCLES) begin
			@(posedge clk);
			n++;
		end
		if (!rst) begin
			$display("reset was never released");
			timeouts++;
		end
		#(DRIVE_DELAY_NS);

		test_name = "store_then_load";
		draw_bits(`MEM_WORDS_LOG2, bits);
		word_a = int'(bits[`MEM_WORDS_LOG2-1:0]);
		draw_bits(32, data);
		do_store(word_addr(word_a, 0), data, 4'hf);
		do_load(word_addr(word_a, 3));

		test_name = "partial_strobes";
		for (int k = 0; k < 4; k++) begin
			draw_bits(`MEM_WORDS_LOG2, bits);
			word_b = int'(bits[`MEM_WORDS_LOG2-1:0]);
			draw_bits(32, data);
			do_store(word_addr(word_b, 0), data, 4'hf);
			for (int p = 0; p < 3; p++) begin
				draw_bits(axi_lite_pkg::STRB_W, bits);
				draw_bits(32, data);
				do_store(word_addr(word_b, p), data, bits[axi_lite_pkg::STRB_W-1:0]);
			end
			do_load(word_addr(word_b, 0));
		end

		test_name = "fetch_written_word";
		do_fetch(word_addr(word_a, 0));

		test_name = "same_cycle_requests";
		word_b = (word_a + 1) % WORDS;
		draw_bits(32, data);
		do_store(word_addr(word_b, 0), data, 4'hf);
		do_fetch_and_load(word_addr(word_a, 0), word_addr(word_b, 0));

		test_name = "out_of_range";
		do_load(word_addr(WORDS + word_a, 0));
		draw_bits(32, data);
		do_store(word_addr(WORDS + word_a, 0), data, 4'hf);
		do_fetch(word_addr(WORDS + word_a, 0));
		do_load(word_addr(word_a, 0));

		protocol_errors = mem_subsystem_i.axi_lite_arbiter_i.mem_subsystem_props_i.fail_count;
		$write("checked %0d fetch and %0d load/store results: ", fetch_count, ls_count);
		$write("%0d value errors, %0d order errors, %0d latency errors, ",
			value_errors, order_errors, latency_errors);
		$display("%0d protocol errors, %0d timeouts", protocol_errors, timeouts);
		if (value_errors == 0 && order_errors == 0 && latency_errors == 0
				&& protocol_errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end
endmodule
